// File: rtl/cmd_classifier.sv
module cmd_classifier (
    input  logic                     clk,
    input  logic                     rst_n,
    input  pi_link_pkg::rx_cmd_t     rx_cmd,
    input  logic                     rx_cmd_valid,
    output pi_link_pkg::routed_cmd_t routed,
    output logic                     routed_valid
);
    import pi_link_pkg::*;

    cmd_class_e cls;
    logic       known;

    // Class nibble sits in the same place in both views
    assign cls = rx_cmd.word.coef.cls;

    always_comb begin
        case (cls)
            CLS_KP,
            CLS_TI,
            CLS_SETPOINT,
            CLS_LIMITS,
            CLS_ENABLE,
            CLS_RESET,
            CLS_WIPE: known = 1'b1;
            default:  known = 1'b0;  // Zero and 8..15
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            routed_valid <= 1'b0;
        end else begin
            routed_valid <= rx_cmd_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (rx_cmd_valid) begin
            routed.cls       <= cls;
            routed.word      <= rx_cmd.word;
            routed.frame_err <= !rx_cmd.len_ok;  // Anything but four payload bytes
            routed.unknown   <= !known;
            routed.mac       <= rx_cmd.mac;
            routed.ip        <= rx_cmd.ip;
        end
    end

    // The framer always spends at least one idle cycle between records
    a_valid_spaced: assert property (@(posedge clk) disable iff (!rst_n)
        routed_valid |=> !routed_valid);

endmodule

// File: rtl/pi_link_pkg.sv
package pi_link_pkg;

    // Top nibble of every command word
    typedef enum logic [3:0] {
        CLS_KP       = 4'd1,
        CLS_TI       = 4'd2,
        CLS_SETPOINT = 4'd3,
        CLS_LIMITS   = 4'd4,
        CLS_ENABLE   = 4'd5,
        CLS_RESET    = 4'd6,
        CLS_WIPE     = 4'd7
    } cmd_class_e;

    // One received word, read either as a coefficient or as a limit pair
    typedef union packed {
        struct packed {
            cmd_class_e  cls;
            logic        rsvd;
            logic [26:0] value;      // Bit 0 doubles as the enable argument
        } coef;
        struct packed {
            cmd_class_e  cls;
            logic [13:0] hi;
            logic [13:0] lo;
        } limit;
    } cmd_word_u;

    // Receive status word, reused as the transmit status
    typedef struct packed {
        logic [47:0] mac;
        logic [31:0] ip;
        logic [15:0] len;
    } rx_status_t;

    typedef struct packed {
        cmd_word_u   word;
        logic        len_ok;
        logic [47:0] mac;
        logic [31:0] ip;
    } rx_cmd_t;

    typedef struct packed {
        cmd_class_e  cls;
        cmd_word_u   word;
        logic        frame_err;
        logic        unknown;
        logic [47:0] mac;
        logic [31:0] ip;
    } routed_cmd_t;

    typedef enum logic [7:0] {
        RPL_ACK = 8'h06,
        RPL_NAK = 8'h15,
        RPL_ERR = 8'h18
    } reply_code_e;

    typedef struct packed {
        logic [7:0]  cls;
        reply_code_e code;
        logic [15:0] mask;           // Bits 0..3 are kp, ti, setpoint, limits
        logic [47:0] mac;
        logic [31:0] ip;
    } reply_t;

    typedef struct packed {
        logic [26:0] kp;
        logic [26:0] ti;
        logic [26:0] setpoint;
        logic [13:0] limit_hi;
        logic [13:0] limit_lo;
    } pi_settings_t;

    // kp lands on bit 0, same order as the written mask
    typedef struct packed {
        logic limits;
        logic setpoint;
        logic ti;
        logic kp;
    } pi_update_t;

    localparam int REPLY_BYTES = 4;

endpackage

// File: rtl/pi_link_top.sv
module pi_link_top #(
    parameter int REPLY_DEPTH = 4
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  pi_link_pkg::rx_status_t   rx_status,
    input  logic                      rx_status_empty,
    output logic                      rx_status_read,
    input  logic [7:0]                rx_data,
    output logic                      rx_data_read,
    input  logic                      rx_data_empty,
    output logic [7:0]                tx_data,
    output logic                      tx_data_write,
    input  logic                      tx_data_full,
    output pi_link_pkg::rx_status_t   tx_status,
    output logic                      tx_status_write,
    input  logic                      tx_status_full,
    input  logic                      dac_stopped,
    output pi_link_pkg::pi_settings_t pi_settings,
    output pi_link_pkg::pi_update_t   pi_update,
    output logic                      pi_enable,
    output logic                      pi_reset
);
    import pi_link_pkg::*;

    rx_cmd_t     rx_cmd;
    logic        rx_cmd_valid;
    routed_cmd_t routed;
    logic        routed_valid;
    reply_t      reply;
    logic        reply_valid;
    logic        reply_busy;   // Back-pressure from the reply queue to the framer

    udp_rx_framer i_udp_rx_framer (
        .clk             (clk),
        .rst_n           (rst_n),
        .rx_status       (rx_status),
        .rx_status_empty (rx_status_empty),
        .rx_status_read  (rx_status_read),
        .rx_data         (rx_data),
        .rx_data_empty   (rx_data_empty),
        .rx_data_read    (rx_data_read),
        .reply_busy      (reply_busy),
        .rx_cmd          (rx_cmd),
        .rx_cmd_valid    (rx_cmd_valid)
    );

    cmd_classifier i_cmd_classifier (
        .clk          (clk),
        .rst_n        (rst_n),
        .rx_cmd       (rx_cmd),
        .rx_cmd_valid (rx_cmd_valid),
        .routed       (routed),
        .routed_valid (routed_valid)
    );

    pi_param_bank i_pi_param_bank (
        .clk          (clk),
        .rst_n        (rst_n),
        .routed       (routed),
        .routed_valid (routed_valid),
        .dac_stopped  (dac_stopped),
        .pi_settings  (pi_settings),
        .pi_update    (pi_update),
        .pi_enable    (pi_enable),
        .pi_reset     (pi_reset),
        .reply        (reply),
        .reply_valid  (reply_valid)
    );

    udp_ack_encoder #(
        .REPLY_DEPTH (REPLY_DEPTH)
    ) i_udp_ack_encoder (
        .clk             (clk),
        .rst_n           (rst_n),
        .reply           (reply),
        .reply_valid     (reply_valid),
        .reply_busy      (reply_busy),
        .tx_data         (tx_data),
        .tx_data_write   (tx_data_write),
        .tx_data_full    (tx_data_full),
        .tx_status       (tx_status),
        .tx_status_write (tx_status_write),
        .tx_status_full  (tx_status_full)
    );

endmodule

// File: rtl/pi_param_bank.sv
module pi_param_bank (
    input  logic                      clk,
    input  logic                      rst_n,
    input  pi_link_pkg::routed_cmd_t  routed,
    input  logic                      routed_valid,
    input  logic                      dac_stopped,
    output pi_link_pkg::pi_settings_t pi_settings,
    output pi_link_pkg::pi_update_t   pi_update,
    output logic                      pi_enable,
    output logic                      pi_reset,
    output pi_link_pkg::reply_t       reply,
    output logic                      reply_valid
);
    import pi_link_pkg::*;

    reply_code_e  code;
    logic         is_write;
    logic         limits_bad;
    logic [3:0]   mask_q;
    logic [3:0]   mask_d;
    pi_settings_t settings_d;
    pi_update_t   update_d;
    logic         enable_d;
    logic         reset_d;

    assign is_write = routed.cls inside {CLS_KP, CLS_TI, CLS_SETPOINT, CLS_LIMITS};
    assign limits_bad = (routed.cls == CLS_LIMITS) &&
                        ($signed(routed.word.limit.hi) < $signed(routed.word.limit.lo));

    // Acceptance rules, first match wins
    always_comb begin
        if (routed.frame_err) begin
            code = RPL_ERR;
        end else if (routed.unknown) begin
            code = RPL_NAK;
        end else if (is_write && !dac_stopped) begin
            code = RPL_NAK;                          // Loop running, settings frozen
        end else if (limits_bad) begin
            code = RPL_ERR;
        end else begin
            code = RPL_ACK;
        end
    end

    always_comb begin
        settings_d = pi_settings;
        update_d   = '0;
        enable_d   = pi_enable;
        reset_d    = 1'b0;
        mask_d     = mask_q;
        if (routed_valid && (code == RPL_ACK)) begin
            case (routed.cls)
                CLS_KP: begin
                    settings_d.kp = routed.word.coef.value;
                    update_d.kp   = 1'b1;
                    mask_d[0]     = 1'b1;
                end
                CLS_TI: begin
                    settings_d.ti = routed.word.coef.value;
                    update_d.ti   = 1'b1;
                    mask_d[1]     = 1'b1;
                end
                CLS_SETPOINT: begin
                    settings_d.setpoint = routed.word.coef.value;
                    update_d.setpoint   = 1'b1;
                    mask_d[2]           = 1'b1;
                end
                CLS_LIMITS: begin
                    settings_d.limit_hi = routed.word.limit.hi;
                    settings_d.limit_lo = routed.word.limit.lo;
                    update_d.limits     = 1'b1;
                    mask_d[3]           = 1'b1;
                end
                CLS_ENABLE: enable_d = routed.word.coef.value[0];
                CLS_RESET: begin
                    reset_d = 1'b1;
                    mask_d  = '0;
                end
                CLS_WIPE: begin
                    settings_d = '0;
                    enable_d   = 1'b0;
                    update_d   = '1;                 // Controller reloads every field
                    mask_d     = '0;
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pi_settings <= '0;
            pi_update   <= '0;
            pi_enable   <= 1'b0;
            pi_reset    <= 1'b0;
            mask_q      <= '0;
            reply_valid <= 1'b0;
        end else begin
            pi_settings <= settings_d;
            pi_update   <= update_d;
            pi_enable   <= enable_d;
            pi_reset    <= reset_d;
            mask_q      <= mask_d;
            reply_valid <= routed_valid;
        end
    end

    // Reply shows the mask as it stands after this command
    always_ff @(posedge clk) begin
        if (routed_valid) begin
            reply.cls  <= {4'h0, routed.cls};
            reply.code <= code;
            reply.mask <= {12'h000, mask_d};
            reply.mac  <= routed.mac;
            reply.ip   <= routed.ip;
        end
    end

endmodule

// File: rtl/udp_ack_encoder.sv
module udp_ack_encoder #(
    parameter int REPLY_DEPTH = 4
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  pi_link_pkg::reply_t     reply,
    input  logic                    reply_valid,
    output logic                    reply_busy,
    output logic [7:0]              tx_data,
    output logic                    tx_data_write,
    input  logic                    tx_data_full,
    output pi_link_pkg::rx_status_t tx_status,
    output logic                    tx_status_write,
    input  logic                    tx_status_full
);
    import pi_link_pkg::*;

    localparam int PTR_W = (REPLY_DEPTH > 1) ? $clog2(REPLY_DEPTH) : 1;
    localparam int CNT_W = $clog2(REPLY_DEPTH + 1);

    reply_t           queue [REPLY_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic [2:0]       stage;   // Payload byte index, REPLY_BYTES selects the status word
    reply_t           head;
    logic             active;
    logic             pop;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(REPLY_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign head   = queue[rd_ptr];
    assign active = (count != '0);

    // Two entries in flight upstream can still land after busy rises
    assign reply_busy = (count >= CNT_W'(2));

    assign tx_data_write   = active && (stage < 3'(REPLY_BYTES)) && !tx_data_full;
    assign tx_status_write = active && (stage == 3'(REPLY_BYTES)) && !tx_status_full;
    assign pop             = tx_status_write;

    always_comb begin
        case (stage)
            3'd0:    tx_data = head.cls;
            3'd1:    tx_data = head.code;
            3'd2:    tx_data = head.mask[15:8];
            default: tx_data = head.mask[7:0];
        endcase
    end

    // Reply goes back to whoever sent the request
    assign tx_status = '{mac: head.mac, ip: head.ip, len: 16'(REPLY_BYTES)};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            stage  <= '0;
        end else begin
            if (reply_valid) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            count <= count + CNT_W'(reply_valid) - CNT_W'(pop);
            if (pop) begin
                stage <= '0;
            end else if (tx_data_write) begin
                stage <= stage + 3'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reply_valid) begin
            queue[wr_ptr] <= reply;
        end
    end

    // Relies on the framer honouring reply_busy
    a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n)
        reply_valid |-> (count < CNT_W'(REPLY_DEPTH)));

    // A reply half sent always has its entry still queued
    a_stage_idle: assert property (@(posedge clk) disable iff (!rst_n)
        (stage != '0) |-> active);

endmodule

// File: rtl/udp_rx_framer.sv
module udp_rx_framer (
    input  logic                    clk,
    input  logic                    rst_n,
    input  pi_link_pkg::rx_status_t rx_status,
    input  logic                    rx_status_empty,
    output logic                    rx_status_read,
    input  logic [7:0]              rx_data,
    input  logic                    rx_data_empty,
    output logic                    rx_data_read,
    input  logic                    reply_busy,
    output pi_link_pkg::rx_cmd_t    rx_cmd,
    output logic                    rx_cmd_valid
);
    import pi_link_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_READ,
        ST_EMIT
    } state_e;

    state_e      state;
    rx_status_t  status_q;
    logic [15:0] byte_cnt;
    logic [31:0] word_q;
    logic        last_byte;

    // Both FIFOs are show-ahead, so the head is consumed in the same cycle
    assign rx_status_read = (state == ST_IDLE) && !rx_status_empty;
    assign rx_data_read   = (state == ST_READ) && !rx_data_empty;
    assign last_byte      = (byte_cnt == status_q.len - 16'd1);

    // Record held until the reply queue has room
    assign rx_cmd_valid = (state == ST_EMIT) && !reply_busy;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= ST_IDLE;
            byte_cnt <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (rx_status_read) begin
                        byte_cnt <= '0;
                        // Empty payload skips straight to emission
                        state    <= (rx_status.len == 16'd0) ? ST_EMIT : ST_READ;
                    end
                end
                ST_READ: begin
                    if (rx_data_read) begin
                        byte_cnt <= byte_cnt + 16'd1;
                        if (last_byte) begin
                            state <= ST_EMIT;
                        end
                    end
                end
                ST_EMIT: begin
                    if (rx_cmd_valid) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rx_status_read) begin
            status_q <= rx_status;
            word_q   <= '0;                          // Short frames read as zero-padded
        end else if (rx_data_read && (byte_cnt < 16'd4)) begin
            word_q <= {word_q[23:0], rx_data};       // MSB first
        end
    end

    // Bytes past the fourth are pulled but dropped, keeping the FIFO aligned
    assign rx_cmd.word   = word_q;
    assign rx_cmd.len_ok = (status_q.len == 16'd4);
    assign rx_cmd.mac    = status_q.mac;
    assign rx_cmd.ip     = status_q.ip;

    // Byte counter stays inside the frame being read
    a_byte_cnt_range: assert property (@(posedge clk) disable iff (!rst_n)
        (state == ST_READ) |-> (byte_cnt < status_q.len));

endmodule

// File: src.f
+incdir+tests
rtl/pi_link_pkg.sv
rtl/udp_rx_framer.sv
rtl/cmd_classifier.sv
rtl/pi_param_bank.sv
rtl/udp_ack_encoder.sv
rtl/pi_link_top.sv
tests/tb_pi_link.sv

// File: tests/tb_pi_link_model.svh
typedef struct packed {
    pi_settings_t settings;
    pi_update_t   update;
    logic         enable;
    logic         reset;
} bank_event_t;

logic [31:0]  lfsr_state = 32'd94705;
pi_settings_t model_settings = '0;
logic         model_enable = 1'b0;
logic [3:0]   model_mask = '0;         // kp, ti, setpoint, limits from bit 0 up
reply_t       exp_replies[$];
bank_event_t  events[$];               // Only commands that raise a strobe or a reset pulse
int           err_count = 0;
int           check_count = 0;

// Galois LFSR, one step per returned bit
function automatic logic [31:0] lfsr_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
        if (lfsr_state[0]) begin
            lfsr_state = (lfsr_state >> 1) ^ 32'hA300_0000;
        end else begin
            lfsr_state = lfsr_state >> 1;
        end
        r = {r[30:0], lfsr_state[0]};
    end
    return r;
endfunction

// Acceptance rules of the bank, applied in frame order
task automatic model_apply(input cmd_word_u word, input logic [15:0] len, input logic stop,
                           input logic [47:0] mac, input logic [31:0] ip);
    reply_t      rep;
    bank_event_t ev;
    reply_code_e code;
    logic [3:0]  cls;
    logic        is_write;
    cls      = word.coef.cls;
    is_write = (cls >= 4'd1) && (cls <= 4'd4);
    ev       = '0;
    if (len != 16'd4) begin
        code = RPL_ERR;
    end else if ((cls == 4'd0) || (cls > 4'd7)) begin
        code = RPL_NAK;
    end else if (is_write && !stop) begin
        code = RPL_NAK;
    end else if ((cls == 4'd4) && ($signed(word.limit.hi) < $signed(word.limit.lo))) begin
        code = RPL_ERR;
    end else begin
        code = RPL_ACK;
        case (cls)
            4'd1: begin
                model_settings.kp = word.coef.value;
                ev.update.kp      = 1'b1;
                model_mask[0]     = 1'b1;
            end
            4'd2: begin
                model_settings.ti = word.coef.value;
                ev.update.ti      = 1'b1;
                model_mask[1]     = 1'b1;
            end
            4'd3: begin
                model_settings.setpoint = word.coef.value;
                ev.update.setpoint      = 1'b1;
                model_mask[2]           = 1'b1;
            end
            4'd4: begin
                model_settings.limit_hi = word.limit.hi;
                model_settings.limit_lo = word.limit.lo;
                ev.update.limits        = 1'b1;
                model_mask[3]           = 1'b1;
            end
            4'd5: model_enable = word.coef.value[0];
            4'd6: begin
                ev.reset   = 1'b1;
                model_mask = '0;
            end
            default: begin                 // Wipe
                model_settings = '0;
                model_enable   = 1'b0;
                ev.update      = '1;
                model_mask     = '0;
            end
        endcase
    end
    if ((ev.update != '0) || ev.reset) begin
        ev.settings = model_settings;
        ev.enable   = model_enable;
        events.push_back(ev);
    end
    rep.cls  = {4'h0, cls};
    rep.code = code;
    rep.mask = {12'h000, model_mask};
    rep.mac  = mac;
    rep.ip   = ip;
    exp_replies.push_back(rep);
endtask

task automatic report_error(input string msg);
    err_count++;
    $display("%s", msg);
endtask

task automatic check_settings(input pi_settings_t exp, input pi_settings_t got);
    check_count++;
    if (got !== exp) begin
        err_count++;
        $display("FAILED pi_settings expected %h got %h", exp, got);
    end
endtask

task automatic check_update(input pi_update_t exp, input pi_update_t got);
    check_count++;
    if (got !== exp) begin
        err_count++;
        $display("FAILED pi_update expected %h got %h", exp, got);
    end
endtask

task automatic check_reply(input reply_t exp, input reply_t got);
    check_count++;
    if (got !== exp) begin
        err_count++;
        $display("FAILED reply expected %h got %h", exp, got);
    end
endtask

task automatic check_status(input rx_status_t exp, input rx_status_t got);
    check_count++;
    if (got !== exp) begin
        err_count++;
        $display("FAILED tx_status expected %h got %h", exp, got);
    end
endtask

task automatic check_flag(input string name, input logic exp, input logic got);
    check_count++;
    if (got !== exp) begin
        err_count++;
        $display("FAILED %s expected %h got %h", name, exp, got);
    end
endtask

// File: tests/tb_pi_link.sv
module tb_pi_link;
    import pi_link_pkg::*;

    localparam int TESTS          = 5;
    localparam int FRAMES         = 400;
    localparam int TIMEOUT_CYCLES = FRAMES * 40;

    logic         clk;
    logic         rst_n;
    rx_status_t   rx_status;
    logic         rx_status_empty;
    logic         rx_status_read;
    logic [7:0]   rx_data;
    logic         rx_data_read;
    logic         rx_data_empty;
    logic [7:0]   tx_data;
    logic         tx_data_write;
    logic         tx_data_full;
    rx_status_t   tx_status;
    logic         tx_status_write;
    logic         tx_status_full;
    logic         dac_stopped;
    pi_settings_t pi_settings;
    pi_update_t   pi_update;
    logic         pi_enable;
    logic         pi_reset;

    `include "tb_pi_link_model.svh"

    rx_status_t   status_q[$];        // Receive status FIFO contents
    logic         stop_q[$];          // DAC state that goes with each frame
    logic [7:0]   data_q[$];
    logic [7:0]   tx_bytes[$];
    pi_settings_t last_settings = '0;
    int           full_level = 2;     // Out of 4, chance of a full transmit FIFO
    int           cycle_count;
    string        test_names[TESTS] = '{"coef_write", "running_unknown", "limit_length_err",
                                        "enable_reset_wipe", "mixed_backpressure"};

    pi_link_top #(
        .REPLY_DEPTH (4)
    ) i_pi_link_top (
        .clk             (clk),
        .rst_n           (rst_n),
        .rx_status       (rx_status),
        .rx_status_empty (rx_status_empty),
        .rx_status_read  (rx_status_read),
        .rx_data         (rx_data),
        .rx_data_read    (rx_data_read),
        .rx_data_empty   (rx_data_empty),
        .tx_data         (tx_data),
        .tx_data_write   (tx_data_write),
        .tx_data_full    (tx_data_full),
        .tx_status       (tx_status),
        .tx_status_write (tx_status_write),
        .tx_status_full  (tx_status_full),
        .dac_stopped     (dac_stopped),
        .pi_settings     (pi_settings),
        .pi_update       (pi_update),
        .pi_enable       (pi_enable),
        .pi_reset        (pi_reset)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Builds one frame with a class mix that suits the test
    task automatic load_frame(input int test);
        logic [31:0] word;
        logic [31:0] seen;
        rx_status_t  st;
        logic [3:0]  cls;
        logic [15:0] len;
        logic        stop;
        logic [7:0]  b;
        len  = 16'd4;
        stop = 1'b1;
        case (test)
            0: cls = 4'd1 + 4'(lfsr_bits(2));
            1: begin
                cls  = 4'(lfsr_bits(4));
                stop = (lfsr_bits(2) == 0);
            end
            2: begin
                cls = CLS_LIMITS;
                if (lfsr_bits(1) != 0) len = 16'(lfsr_bits(3));
            end
            3: begin
                cls  = (lfsr_bits(1) != 0) ? 4'd5 + 4'(lfsr_bits(2) % 3) : 4'd1 + 4'(lfsr_bits(2));
                stop = (lfsr_bits(2) != 0);
            end
            default: begin
                cls  = 4'(lfsr_bits(4));
                stop = 1'(lfsr_bits(1));
                if (lfsr_bits(2) == 0) len = 16'(lfsr_bits(3));
            end
        endcase
        word   = {cls, 28'(lfsr_bits(28))};
        st.mac = {lfsr_bits(32), 16'(lfsr_bits(16))};
        st.ip  = lfsr_bits(32);
        st.len = len;
        seen   = '0;
        for (int i = 0; i < len; i++) begin
            b = ((len >= 16'd4) && (i < 4)) ? word[31 - 8 * i -: 8] : 8'(lfsr_bits(8));
            if (i < 4) seen = {seen[23:0], b};   // Short frames arrive zero padded
            data_q.push_back(b);
        end
        status_q.push_back(st);
        stop_q.push_back(stop);
        model_apply(seen, len, stop, st.mac, st.ip);
    endtask

    task automatic observe_tx();
        reply_t     exp;
        reply_t     got;
        rx_status_t exp_status;
        if ((tx_data_write && tx_data_full) || (tx_status_write && tx_status_full)) begin
            report_error("transmit FIFO written while it was full");
        end
        if (tx_data_write) tx_bytes.push_back(tx_data);
        if (tx_status_write) begin
            if (exp_replies.size() == 0) begin
                report_error("reply sent with no request pending");
            end else if (tx_bytes.size() != REPLY_BYTES) begin
                void'(exp_replies.pop_front());
                report_error($sformatf("reply carried %0d payload bytes", tx_bytes.size()));
            end else begin
                exp        = exp_replies.pop_front();
                got.cls    = tx_bytes[0];
                got.code   = reply_code_e'(tx_bytes[1]);
                got.mask   = {tx_bytes[2], tx_bytes[3]};
                got.mac    = tx_status.mac;
                got.ip     = tx_status.ip;
                exp_status.mac = exp.mac;
                exp_status.ip  = exp.ip;
                exp_status.len = 16'd4;
                check_reply(exp, got);
                check_status(exp_status, tx_status);
            end
            tx_bytes.delete();
        end
    endtask

    task automatic observe_bank();
        bank_event_t ev;
        if ((pi_update != '0) || pi_reset) begin
            if (events.size() == 0) begin
                report_error("update strobe or reset pulse with no accepted command pending");
            end else begin
                ev = events.pop_front();
                check_update(ev.update, pi_update);
                check_flag("pi_reset", ev.reset, pi_reset);
                check_flag("pi_enable", ev.enable, pi_enable);
                check_settings(ev.settings, pi_settings);
                last_settings = ev.settings;
            end
        end else if (pi_settings !== last_settings) begin
            check_settings(last_settings, pi_settings);   // Changed without a strobe
            last_settings = pi_settings;
        end
    endtask

    // FIFO models, observed at the falling edge and driven just after the rising one
    initial begin : fifo_models
        logic status_pop;
        logic data_pop;
        rx_status       = '0;
        rx_status_empty = 1'b1;
        rx_data         = '0;
        rx_data_empty   = 1'b1;
        tx_data_full    = 1'b0;
        tx_status_full  = 1'b0;
        dac_stopped     = 1'b0;
        forever begin
            @(negedge clk);
            status_pop = rst_n && rx_status_read;
            data_pop   = rst_n && rx_data_read;
            if (rst_n) begin
                observe_tx();
                observe_bank();
            end
            @(posedge clk);
            #1;
            if (status_pop && (status_q.size() != 0)) begin
                void'(status_q.pop_front());
                dac_stopped = stop_q.pop_front();
            end
            if (data_pop && (data_q.size() != 0)) void'(data_q.pop_front());
            rx_status_empty = (status_q.size() == 0);
            rx_status       = rx_status_empty ? '0 : status_q[0];
            rx_data_empty   = (data_q.size() == 0);
            rx_data         = rx_data_empty ? 8'h00 : data_q[0];
            tx_data_full    = (lfsr_bits(2) < full_level);
            tx_status_full  = (lfsr_bits(2) < full_level);
        end
    end

    initial begin : watchdog
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Run stopped after %0d cycles with %0d replies still outstanding",
                 cycle_count, exp_replies.size());
        $display("Result: FAILED");
        $finish;
    end

    initial begin : main
        int errors_before;
        rst_n = 1'b0;
        repeat (8) @(posedge clk);
        #1 rst_n = 1'b1;
        for (int t = 0; t < TESTS; t++) begin
            @(posedge clk);
            #2;
            errors_before = err_count;
            full_level    = (t == TESTS - 1) ? 3 : 2;
            for (int f = 0; f < FRAMES / TESTS; f++) begin
                load_frame(t);
            end
            while ((exp_replies.size() != 0) || (status_q.size() != 0) ||
                   (events.size() != 0)) begin
                @(posedge clk);
                #2;
            end
            check_flag("pi_enable", model_enable, pi_enable);
            $display("test %0d %s: %0d frames, %0d errors", t, test_names[t],
                     FRAMES / TESTS, err_count - errors_before);
        end
        if (data_q.size() != 0) begin
            report_error($sformatf("%0d receive bytes were never read", data_q.size()));
        end
        $display("tests %0d, frames %0d, checks %0d, errors %0d",
                 TESTS, FRAMES, check_count, err_count);
        if (err_count == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule
